//--- source/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// --------------------------------------------------
// Pipeline sizing
// --------------------------------------------------

// Data memory depth in 32-bit words
// Address bits above the index wrap around
`define DMEM_WORDS 64

// Architectural registers, r0 hardwired to zero
`define REG_COUNT 32

`endif

//--- source/pipePkg.sv
`default_nettype none

package pipePkg;

    typedef logic [31:0] word_t;    // Data and instruction word
    typedef logic [4:0]  regIdx_t;  // Register number

    // Major opcodes in instr[31:26]
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_t;

    // R-type function codes in instr[5:0]
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_t;

    // Two-bit destination select, same coding as the old hazard block
    typedef enum logic [1:0] {
        destRt   = 2'b00,   // Loads and addi
        destRd   = 2'b01,   // R-type
        destNone = 2'b10    // Stores and nop
    } regDst_t;

    typedef enum logic [1:0] {
        fromReg   = 2'b00,  // Value read in decode
        fromExMem = 2'b01,  // ALU result one stage ahead
        fromMemWb = 2'b10   // Writeback value two stages ahead
    } fwdSel_t;

    // Operand pick shared by the ALU inputs and the store data path
    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t exMemVal,
                                     word_t memWbVal);
        case (sel)
            fromExMem: return exMemVal;
            fromMemWb: return memWbVal;
            default:   return regVal;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
    input  pipePkg::word_t   instr,
    output pipePkg::regIdx_t rs,
    output pipePkg::regIdx_t rt,
    output pipePkg::regIdx_t rd,
    output pipePkg::word_t   imm,
    output logic             regWrite,
    output logic             memRead,
    output logic             memWrite,
    output logic             aluSrcImm,
    output pipePkg::aluOp_t  aluOp,
    output pipePkg::regDst_t regDst
);
    import pipePkg::*;

    opcode_t opcode;
    funct_t  funct;

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------
    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm    = {{16{instr[15]}}, instr[15:0]};    // Sign extended

    // --------------------------------------------------
    // Control generation
    // --------------------------------------------------
    always_comb begin
        // Everything defaults to a nop
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        aluSrcImm = 1'b0;
        aluOp     = aluAdd;
        regDst    = destNone;
        case (opcode)
            opRType: begin
                regWrite = 1'b1;
                regDst   = destRd;
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: begin
                        regWrite = 1'b0;    // All-zero word lands here too
                        regDst   = destNone;
                    end
                endcase
            end
            opAddi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                regDst    = destRt;
            end
            opLw: begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                aluSrcImm = 1'b1;           // Address is rs + imm
                regDst    = destRt;
            end
            opSw: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            default: ;                      // Unknown opcode stays a nop
        endcase
    end

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
    input  pipePkg::regIdx_t rsIfId,
    input  pipePkg::regIdx_t rtIfId,
    input  pipePkg::regIdx_t rtIdEx,
    input  pipePkg::regIdx_t rdIdEx,
    input  logic             memReadIdEx,
    input  pipePkg::regDst_t regDstIdEx,
    output logic             pcWrite,
    output logic             ifIdWrite,
    output logic             controlStall
);
    import pipePkg::*;

    regIdx_t loadDest;  // Register the load in ID/EX will write
    logic    loadUse;

    always_comb begin
        case (regDstIdEx)
            destRt:  loadDest = rtIdEx;
            destRd:  loadDest = rdIdEx;
            default: loadDest = '0;
        endcase
    end

    // --------------------------------------------------
    // Load-use detection
    // --------------------------------------------------
    // Load data shows up only in MEM/WB, one cycle too late for EX
    // r0 never needs a stall since it is never forwarded
    assign loadUse = memReadIdEx && (loadDest != '0)
                     && ((loadDest == rsIfId) || (loadDest == rtIfId));

    assign pcWrite      = !loadUse;     // Hold the incoming word
    assign ifIdWrite    = !loadUse;     // Keep the consumer in IF/ID
    assign controlStall = loadUse;      // Bubble into ID/EX

endmodule

`default_nettype wire

//--- source/forwardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module forwardUnit (
    input  pipePkg::regIdx_t rsIdEx,
    input  pipePkg::regIdx_t rtIdEx,
    input  pipePkg::regIdx_t destExMem,
    input  pipePkg::regIdx_t destMemWb,
    input  logic             regWriteExMem,
    input  logic             regWriteMemWb,
    output pipePkg::fwdSel_t fwdA,
    output pipePkg::fwdSel_t fwdB
);
    import pipePkg::*;

    // --------------------------------------------------
    // Newest producer wins
    // --------------------------------------------------
    function automatic fwdSel_t pickSource(regIdx_t src);
        if (src == '0) begin
            return fromReg;                         // r0 is always zero
        end else if (regWriteExMem && (destExMem == src)) begin
            return fromExMem;                       // One instruction ahead
        end else if (regWriteMemWb && (destMemWb == src)) begin
            return fromMemWb;                       // Two ahead
        end
        return fromReg;
    endfunction

    assign fwdA = pickSource(rsIdEx);
    assign fwdB = pickSource(rtIdEx);   // Also feeds the store data

endmodule

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::regIdx_t rdAddrA,
    input  pipePkg::regIdx_t rdAddrB,
    input  pipePkg::regIdx_t wrAddr,
    input  logic             wrEn,
    input  pipePkg::word_t   wrData,
    output pipePkg::word_t   rdDataA,
    output pipePkg::word_t   rdDataB
);
    import pipePkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;     // r0 writes dropped
        end
    end

    // --------------------------------------------------
    // Read ports
    // --------------------------------------------------
    // Writeback in the same cycle is passed straight through
    function automatic word_t readPort(regIdx_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wrEn && (wrAddr == addr)) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    assign rdDataA = readPort(rdAddrA);
    assign rdDataB = readPort(rdAddrB);

endmodule

`default_nettype wire

//--- source/aluExec.sv
`timescale 1ns/100ps
`default_nettype none

module aluExec (
    input  pipePkg::fwdSel_t fwdA,
    input  pipePkg::fwdSel_t fwdB,
    input  pipePkg::word_t   regA,
    input  pipePkg::word_t   regB,
    input  pipePkg::word_t   exMemValue,
    input  pipePkg::word_t   memWbValue,
    input  pipePkg::word_t   imm,
    input  logic             aluSrcImm,
    input  pipePkg::aluOp_t  aluOp,
    input  pipePkg::regIdx_t rt,
    input  pipePkg::regIdx_t rd,
    input  pipePkg::regDst_t regDst,
    output pipePkg::word_t   result,
    output pipePkg::regIdx_t dest
);
    import pipePkg::*;

    word_t opA;
    word_t opB;
    word_t srcB;    // Second operand after the immediate mux

    // Operand selection
    assign opA  = fwdMux(fwdA, regA, exMemValue, memWbValue);
    assign opB  = fwdMux(fwdB, regB, exMemValue, memWbValue);
    assign srcB = aluSrcImm ? imm : opB;

    // --------------------------------------------------
    // Operation
    // --------------------------------------------------
    always_comb begin
        case (aluOp)
            aluSub:  result = opA - srcB;
            aluAnd:  result = opA & srcB;
            aluOr:   result = opA | srcB;
            aluSlt:  result = {31'b0, $signed(opA) < $signed(srcB)};   // Signed compare
            default: result = opA + srcB;       // add, addi, lw/sw address
        endcase
    end

    // Destination register
    always_comb begin
        case (regDst)
            destRt:  dest = rt;
            destRd:  dest = rd;
            default: dest = '0;     // No write
        endcase
    end

endmodule

`default_nettype wire

//--- source/dataMem.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module dataMem (
    input  logic           clk,
    input  pipePkg::word_t addr,
    input  logic           wrEn,
    input  logic           rdEn,
    input  pipePkg::word_t wrData,
    output pipePkg::word_t rdData
);
    import pipePkg::*;

    localparam int IdxW = $clog2(`DMEM_WORDS);

    word_t            mem [`DMEM_WORDS];
    logic [IdxW-1:0]  wordIdx;

    // Byte address to word index, upper bits wrap
    assign wordIdx = addr[IdxW+1:2];

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
        if (rdEn) begin
            rdData <= mem[wordIdx];     // Lands in the MEM/WB cycle
        end
    end

    // Only whole-word accesses exist
    alignedAccess: assert property (@(posedge clk) (rdEn || wrEn) |-> (addr[1:0] == 2'b00))
        else $error("dataMem unaligned address %h", addr);

endmodule

`default_nettype wire

//--- source/pipeCore.sv
`timescale 1ns/100ps
`default_nettype none

module pipeCore (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    input  pipePkg::word_t   instrData,
    output logic             instrReady,
    output logic             retireValid,
    output pipePkg::regIdx_t retireDest,
    output pipePkg::word_t   retireData
);
    import pipePkg::*;

    word_t   ifIdInstr;

    // Decode stage
    regIdx_t decRs, decRt, decRd;
    word_t   decImm, rfDataA, rfDataB;
    logic    decRegWrite, decMemRead, decMemWrite, decAluSrcImm;
    aluOp_t  decAluOp;
    regDst_t decRegDst;
    logic    pcWrite, ifIdWrite, controlStall;

    // ID/EX
    logic    idExRegWrite, idExMemRead, idExMemWrite, idExAluSrcImm;
    aluOp_t  idExAluOp;
    regDst_t idExRegDst;
    regIdx_t idExRs, idExRt, idExRd;
    word_t   idExRegA, idExRegB, idExImm;

    // Execute stage
    fwdSel_t fwdA, fwdB;
    word_t   aluResult;
    regIdx_t aluDest;

    // EX/MEM and MEM/WB
    logic    exMemRegWrite, exMemMemRead, exMemMemWrite;
    regIdx_t exMemDest;
    word_t   exMemResult, exMemStoreData, memRdData;
    logic    memWbRegWrite, memWbMemRead;
    regIdx_t memWbDest;
    word_t   memWbResult, wbData;

    assign instrReady = pcWrite;    // Stream stalls with the PC

    // --------------------------------------------------
    // IF/ID
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifIdInstr <= '0;
        end else if (ifIdWrite) begin
            ifIdInstr <= instrValid ? instrData : '0;   // Idle stream becomes a nop
        end
    end

    instrDecode u_instrDecode (
        .instr(ifIdInstr), .rs(decRs), .rt(decRt), .rd(decRd), .imm(decImm),
        .regWrite(decRegWrite), .memRead(decMemRead), .memWrite(decMemWrite),
        .aluSrcImm(decAluSrcImm), .aluOp(decAluOp), .regDst(decRegDst)
    );

    regFile u_regFile (
        .clk(clk), .rstN(rstN), .rdAddrA(decRs), .rdAddrB(decRt),
        .wrAddr(memWbDest), .wrEn(memWbRegWrite), .wrData(wbData),
        .rdDataA(rfDataA), .rdDataB(rfDataB)
    );

    hazardUnit u_hazardUnit (
        .rsIfId(decRs), .rtIfId(decRt), .rtIdEx(idExRt), .rdIdEx(idExRd),
        .memReadIdEx(idExMemRead), .regDstIdEx(idExRegDst),
        .pcWrite(pcWrite), .ifIdWrite(ifIdWrite), .controlStall(controlStall)
    );

    // --------------------------------------------------
    // ID/EX
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN || controlStall) begin
            if (!rstN) begin
                idExRs <= '0;
                idExRt <= '0;
                idExRd <= '0;
            end
            idExRegWrite  <= 1'b0;      // Bubble
            idExMemRead   <= 1'b0;
            idExMemWrite  <= 1'b0;
            idExAluSrcImm <= 1'b0;
            idExAluOp     <= aluAdd;
            idExRegDst    <= destNone;
        end else begin
            idExRegWrite  <= decRegWrite;
            idExMemRead   <= decMemRead;
            idExMemWrite  <= decMemWrite;
            idExAluSrcImm <= decAluSrcImm;
            idExAluOp     <= decAluOp;
            idExRegDst    <= decRegDst;
            idExRs        <= decRs;
            idExRt        <= decRt;
            idExRd        <= decRd;
        end
    end

    always_ff @(posedge clk) begin
        idExRegA <= rfDataA;
        idExRegB <= rfDataB;
        idExImm  <= decImm;
    end

    forwardUnit u_forwardUnit (
        .rsIdEx(idExRs), .rtIdEx(idExRt), .destExMem(exMemDest), .destMemWb(memWbDest),
        .regWriteExMem(exMemRegWrite), .regWriteMemWb(memWbRegWrite),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    aluExec u_aluExec (
        .fwdA(fwdA), .fwdB(fwdB), .regA(idExRegA), .regB(idExRegB),
        .exMemValue(exMemResult), .memWbValue(wbData), .imm(idExImm),
        .aluSrcImm(idExAluSrcImm), .aluOp(idExAluOp), .rt(idExRt), .rd(idExRd),
        .regDst(idExRegDst), .result(aluResult), .dest(aluDest)
    );

    // --------------------------------------------------
    // EX/MEM and MEM/WB
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
            exMemDest     <= '0;
            memWbRegWrite <= 1'b0;
            memWbMemRead  <= 1'b0;
            memWbDest     <= '0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
            exMemDest     <= aluDest;
            memWbRegWrite <= exMemRegWrite;
            memWbMemRead  <= exMemMemRead;
            memWbDest     <= exMemDest;
        end
    end

    always_ff @(posedge clk) begin
        exMemResult    <= aluResult;
        exMemStoreData <= fwdMux(fwdB, idExRegB, exMemResult, wbData);  // Forwarded rt
        memWbResult    <= exMemResult;
    end

    dataMem u_dataMem (
        .clk(clk), .addr(exMemResult), .wrEn(exMemMemWrite), .rdEn(exMemMemRead),
        .wrData(exMemStoreData), .rdData(memRdData)
    );

    // Writeback and retire
    assign wbData      = memWbMemRead ? memRdData : memWbResult;
    assign retireValid = memWbRegWrite && (memWbDest != '0);
    assign retireDest  = memWbDest;
    assign retireData  = wbData;

    // Bubble clears ID/EX memRead so a stall never repeats
    readyGap: assert property (@(posedge clk) disable iff (!rstN) !instrReady |=> instrReady)
        else $error("instrReady low for two cycles");

endmodule

`default_nettype wire

//--- dv/pipeCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module pipeCoreTb;
    import pipePkg::*;

    localparam int VecWords    = 256;
    localparam int DrainCycles = 8;     // Pipeline depth plus margin

    logic    clk;
    logic    rstN;
    logic    instrValid;
    word_t   instrData;
    logic    instrReady;
    logic    retireValid;
    regIdx_t retireDest;
    word_t   retireData;

    word_t   vec [VecWords];        // Raw vector file contents
    regIdx_t expDest [$];           // Expected retirements, whole run
    word_t   expData [$];

    logic [15:0] lfsr;
    int          cycleLimit;

    // Owned by the monitor
    logic prevLow;
    int   stallCycles;
    int   retireCount;
    int   monitorErrors;

    // Owned by the main flow
    int flowErrors;
    int passCount;
    int failCount;

    pipeCore u_pipeCore (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instrData(instrData),
        .instrReady(instrReady), .retireValid(retireValid), .retireDest(retireDest),
        .retireData(retireData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic string testName(int idx);
        case (idx)
            0:       return "aluChain";
            1:       return "addiNegative";
            2:       return "storeLoad";
            3:       return "loadUse";
            4:       return "regZero";
            5:       return "randomGaps";
            default: return "extra";
        endcase
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic nextLfsrBit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    // Present one word and hold it until the edge that accepts it
    task automatic sendWord(input word_t w);
        logic rdy;
        instrValid <= 1'b1;
        instrData  <= w;
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            rdy = instrReady;       // Stable between edges
            @(posedge clk);
        end
    endtask

    // --------------------------------------------------
    // Monitor
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!rstN) begin
            prevLow       = 1'b0;
            stallCycles   = 0;
            retireCount   = 0;
            monitorErrors = 0;
        end else begin
            if (!instrReady) begin
                stallCycles++;
                assert (!prevLow) else begin
                    $display("instrReady stayed low for two cycles in a row at %0t", $time);
                    monitorErrors++;
                end
            end
            prevLow = !instrReady;
            if (retireValid) begin
                assert (retireCount < expDest.size()) else begin
                    $display("Retirement of r%0d that the program does not produce",
                             retireDest);
                    monitorErrors++;
                end
                if (retireCount < expDest.size()) begin
                    assert (retireDest == expDest[retireCount]) else begin
                        $display("Mismatch retireDest expected %h got %h",
                                 expDest[retireCount], retireDest);
                        monitorErrors++;
                    end
                    assert (retireData == expData[retireCount]) else begin
                        $display("Mismatch retireData expected %h got %h",
                                 expData[retireCount], retireData);
                        monitorErrors++;
                    end
                end
                retireCount++;      // Program order
            end
        end
    end

    // --------------------------------------------------
    // Timeout
    // --------------------------------------------------
    initial begin : watchdog
        int cycleCount;
        cycleCount = 0;
        @(posedge rstN);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles without reaching the end of the tests",
                 cycleLimit);
        $display("Finished with errors");
        $finish;
    end

    // --------------------------------------------------
    // Main flow
    // --------------------------------------------------
    initial begin : mainFlow
        int   numTests;
        int   totalInstr;
        int   ptr;
        int   numInstr;
        int   numExp;
        int   gapMode;
        int   wantStalls;
        int   gap;
        int   stallBase;
        int   errBase;
        logic hiBit;
        logic loBit;

        rstN       = 1'b0;
        instrValid = 1'b0;
        instrData  = '0;
        lfsr       = 16'd36125;
        flowErrors = 0;
        passCount  = 0;
        failCount  = 0;

        $readmemh("dv/pipeVectors.txt", vec);
        numTests = $isunknown(vec[0]) ? 0 : int'(vec[0]);

        // Limit from the total instruction count
        totalInstr = 0;
        ptr        = 1;
        for (int t = 0; t < numTests; t++) begin
            totalInstr += int'(vec[ptr]);
            ptr += 4 + int'(vec[ptr]) + 2 * int'(vec[ptr + 1]);
        end
        cycleLimit = totalInstr * 8 + 200;

        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        assert (numTests > 0) else begin
            $display("Vector file dv/pipeVectors.txt is missing or holds no tests");
            flowErrors++;
        end

        ptr = 1;
        for (int t = 0; t < numTests; t++) begin
            numInstr   = int'(vec[ptr]);
            numExp     = int'(vec[ptr + 1]);
            gapMode    = int'(vec[ptr + 2]);
            wantStalls = int'(vec[ptr + 3]);
            ptr += 4;
            for (int e = 0; e < numExp; e++) begin
                expDest.push_back(vec[ptr + numInstr + 2 * e][4:0]);
                expData.push_back(vec[ptr + numInstr + 2 * e + 1]);
            end
            stallBase = stallCycles;
            errBase   = monitorErrors + flowErrors;

            for (int i = 0; i < numInstr; i++) begin
                if (gapMode != 0) begin
                    hiBit = nextLfsrBit();
                    loBit = nextLfsrBit();
                    gap   = int'({hiBit, loBit});       // 0 to 3 idle cycles
                    if (gap > 0) begin
                        instrValid <= 1'b0;
                        repeat (gap) @(posedge clk);
                    end
                end
                sendWord(vec[ptr + i]);
            end
            instrValid <= 1'b0;
            instrData  <= '0;

            // Last retirement of this test, then a quiet window for extras
            while (retireCount < expDest.size()) @(posedge clk);
            repeat (DrainCycles) @(posedge clk);

            if (gapMode == 0) begin
                assert (stallCycles - stallBase == wantStalls) else begin
                    $display("Test %s held instrReady low for %0d cycles instead of %0d",
                             testName(t), stallCycles - stallBase, wantStalls);
                    flowErrors++;
                end
            end

            if (monitorErrors + flowErrors == errBase) begin
                passCount++;
                $display("Test %0d %s passed", t, testName(t));
            end else begin
                failCount++;
                $display("Test %0d %s failed", t, testName(t));
            end
            ptr += numInstr + 2 * numExp;
        end

        $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount,
                 monitorErrors + flowErrors);
        if (monitorErrors + flowErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/pipePkg.sv
source/instrDecode.sv
source/hazardUnit.sv
source/forwardUnit.sv
source/regFile.sv
source/aluExec.sv
source/dataMem.sv
source/pipeCore.sv
dv/pipeCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module pipeCoreTb --Mdir obj_dir -o pipeCoreSim

# The log decides pass or fail, not the simulator status
./obj_dir/pipeCoreSim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Finished with no errors" "$LOG"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- dv/pipeVectors.txt
// Word 0 is the test count. Per test a header of instruction count, retirement count,
// gap mode (0 back to back, 1 random idle cycles) and instrReady low cycles for mode 0,
// then the instruction words, then one destination and value pair per retirement
06
// Test aluChain with each result feeding the next
08 08 0 0
20010007 20020005 00221820 00612022 00832824 00A13025 00C2382A 0046402A
01 00000007 02 00000005 03 0000000C 04 00000005
05 00000004 06 00000007 07 00000000 08 00000001
// Test addiNegative with sign extension and a signed slt
04 04 1 0
2029FFF6 212A8000 0149582A 200C7FFF
09 FFFFFFFD 0A FFFF7FFD 0B 00000001 0C 00007FFF
// Test storeLoad on two neighbouring words
05 03 1 0
200D0040 ADA30000 ADAA0004 8DAE0004 8DAF0000
0D 00000040 0E FFFF7FFD 0F 0000000C
// Test loadUse with two back to back load consumers
05 05 0 2
8DB00000 02018820 8DB20004 00529822 0270A025
10 0000000C 11 00000013 12 FFFF7FFD 13 00008008 14 0000800C
// Test regZero where writes to r0 never retire
05 02 1 0
20200063 00220020 8DA00000 0001A820 20160003
15 00000007 16 00000003
// Test randomGaps mixing memory, ALU and a nop
0A 08 1 0
20170100 AEF50008 8EF80008 0318C820 0337D022 0340D82A 0357E024 00000000 039BE825 23BEFFFF
17 00000100 18 00000007 19 0000000E 1A FFFFFF0E
1B 00000001 1C 00000100 1D 00000101 1E 00000100
